// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int WORD_W = 16;  // program word
  localparam int ADDR_W = 6;  // 64 words
  localparam int PAGE_W = 3;  // segment / logical page index
  localparam int OFFSET_W = ADDR_W - PAGE_W;  // word within page
  localparam int PAGE_WORDS = 2 ** OFFSET_W;  // 8 words per page
  localparam int RAM_WORDS = 2 ** ADDR_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  // same word, seen raw or split into opcode / operand bytes
  typedef union packed {
    word_t raw;
    struct packed {
      logic [7:0] opcode;
      logic [7:0] operand;
    } op;
  } program_word_t;

  // chain 0->3->6->1->4->7, 7 ends on itself, 2 and 5 off chain
  localparam logic [PAGE_W-1:0] PAGE_CHAIN [0:7] = '{3'd3, 3'd4, 3'd2, 3'd6, 3'd7, 3'd5, 3'd1, 3'd7};
  // logical page held by each segment
  localparam logic [PAGE_W-1:0] PAGE_LOGICAL [0:7] = '{3'd0, 3'd3, 3'd7, 3'd1, 3'd4, 3'd7, 3'd2, 3'd5};
  localparam logic [PAGE_W-1:0] START_SEGMENT = 3'd0;

  localparam addr_t FETCH_BASE = 6'd40;  // logical page 5, offset 0
  localparam int FETCH_COUNT = 5;
  localparam int FETCH_IDX_W = 3;

  localparam logic [7:0] SIG_OPCODE = 8'h0C;  // offsets 0 and 2
  localparam word_t SIG_RAW_1 = 16'h0001;
  localparam word_t SIG_RAW_3 = 16'h0002;
  localparam word_t SIG_RAW_4 = 16'h0402;
  localparam logic [7:0] SIG_CHARS [0:FETCH_COUNT-1] = '{"A", "R", "C", "I", "N"};
  localparam logic [7:0] CHAR_MISS = "X";
  localparam logic [7:0] CHAR_BANNER = "M";

  localparam int CLKS_PER_BIT = 16;  // sim rate
  localparam int CYCLE_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int FRAME_BITS = 10;  // start + 8 data + stop
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // page walker states
  localparam logic [1:0] WALK_IDLE = 2'd0;
  localparam logic [1:0] WALK_STEP = 2'd1;
  localparam logic [1:0] WALK_READ = 2'd2;

  // fetcher states
  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_BANNER = 3'd1;
  localparam logic [2:0] ST_REQUEST = 3'd2;
  localparam logic [2:0] ST_WAIT = 3'd3;
  localparam logic [2:0] ST_EMIT = 3'd4;
  localparam logic [2:0] ST_DRAIN = 3'd5;

endpackage

`default_nettype wire

// File: src/mem_read_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_read_if;
  import fetch_pkg::*;

  logic exec;  // one-cycle request strobe
  addr_t address;  // logical, held until ready
  logic ready;  // one-cycle done strobe
  word_t value;  // valid with ready

  modport requester (
    output exec, address,
    input ready, value
  );

  modport responder (
    input exec, address,
    output ready, value
  );

endinterface

`default_nettype wire

// File: src/program_ram.sv
`timescale 1ns/1ps
`default_nettype none

module program_ram (
  input logic clk,
  input logic write_enable,
  input fetch_pkg::addr_t write_address,
  input fetch_pkg::word_t write_data,
  input fetch_pkg::addr_t read_address,
  output fetch_pkg::word_t read_data
);
  import fetch_pkg::*;

  word_t mem [0:RAM_WORDS-1];  // host-loaded program image

  // host load port
  always_ff @(posedge clk) begin
    if (write_enable) begin
      mem[write_address] <= write_data;  // commits on this edge
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    read_data <= mem[read_address];
  end

endmodule

`default_nettype wire

// File: src/page_walker.sv
`timescale 1ns/1ps
`default_nettype none

module page_walker (
  input logic clk,
  input logic read_address_ready,
  mem_read_if.responder rd,
  input logic load_valid,
  input fetch_pkg::addr_t load_address,
  input fetch_pkg::word_t load_data
);
  import fetch_pkg::*;

  logic [1:0] state;
  logic [PAGE_W-1:0] segment;  // current chain position
  logic [PAGE_W-1:0] page;  // logical page of request
  logic [OFFSET_W-1:0] offset;  // word within page
  addr_t ram_read_address;
  word_t ram_read_data;

  // physical word = segment base + offset
  function automatic addr_t map_address(input logic [PAGE_W-1:0] seg,
                                        input logic [OFFSET_W-1:0] off);
    return addr_t'(seg * PAGE_WORDS) + addr_t'(off);
  endfunction

  assign page = rd.address[ADDR_W-1 -: PAGE_W];  // upper bits
  assign offset = rd.address[OFFSET_W-1:0];  // address held by requester
  assign rd.value = ram_read_data;  // stable until next request

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      state <= WALK_IDLE;
      segment <= '0;
      ram_read_address <= '0;
      rd.ready <= 1'b0;
    end else begin
      rd.ready <= 1'b0;  // strobe by default
      case (state)
        WALK_IDLE: begin
          if (rd.exec) begin
            if (page == '0) begin
              // page 0 always lives in the start segment
              ram_read_address <= map_address(START_SEGMENT, offset);
              state <= WALK_READ;
            end else begin
              segment <= PAGE_CHAIN[START_SEGMENT];  // first link
              state <= WALK_STEP;
            end
          end
        end
        WALK_STEP: begin
          if (PAGE_LOGICAL[segment] == page) begin
            ram_read_address <= map_address(segment, offset);  // found
            state <= WALK_READ;
          end else begin
            segment <= PAGE_CHAIN[segment];  // one link per cycle
          end
        end
        WALK_READ: begin
          rd.ready <= 1'b1;  // ram data lands with this edge
          state <= WALK_IDLE;
        end
        default: begin
          state <= WALK_IDLE;
        end
      endcase
    end
  end

  program_ram program_ram_inst (
    .clk(clk),
    .write_enable(load_valid),
    .write_address(load_address),  // host writes physical words
    .write_data(load_data),
    .read_address(ram_read_address),
    .read_data(ram_read_data)
  );

endmodule

`default_nettype wire

// File: src/signature_fetcher.sv
`timescale 1ns/1ps
`default_nettype none

module signature_fetcher (
  input logic clk,
  input logic read_address_ready,
  input logic run,
  mem_read_if.requester rd,
  output logic push,
  output logic [7:0] push_char,
  input logic full,
  input logic drained,
  output logic busy
);
  import fetch_pkg::*;

  logic [2:0] state;
  logic [FETCH_IDX_W-1:0] word_idx;  // 0..4
  logic [7:0] char_reg;  // char for last returned word
  program_word_t fetched;
  logic last_word;

  // compare one word against its signature entry
  function automatic logic [7:0] sig_char(input logic [FETCH_IDX_W-1:0] idx,
                                          input program_word_t w);
    logic hit;
    case (idx)
      3'd0, 3'd2: hit = (w.op.opcode == SIG_OPCODE);  // opcode byte only
      3'd1: hit = (w.raw == SIG_RAW_1);
      3'd3: hit = (w.raw == SIG_RAW_3);
      3'd4: hit = (w.raw == SIG_RAW_4);
      default: hit = 1'b0;
    endcase
    return hit ? SIG_CHARS[idx] : CHAR_MISS;
  endfunction

  assign fetched.raw = rd.value;
  assign last_word = (word_idx == FETCH_IDX_W'(FETCH_COUNT - 1));

  assign rd.exec = (state == ST_REQUEST);  // one cycle per word
  assign rd.address = FETCH_BASE + addr_t'(word_idx);  // held through wait

  // push only when the fifo has room
  assign push = ((state == ST_BANNER) || (state == ST_EMIT)) && !full;
  assign push_char = (state == ST_BANNER) ? CHAR_BANNER : char_reg;
  assign busy = (state != ST_IDLE);

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      state <= ST_IDLE;
      word_idx <= '0;
      char_reg <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (run) begin
            word_idx <= '0;
            state <= ST_BANNER;
          end
        end
        ST_BANNER: begin
          if (!full) state <= ST_REQUEST;  // banner pushed this cycle
        end
        ST_REQUEST: begin
          state <= ST_WAIT;
        end
        ST_WAIT: begin
          if (rd.ready) begin
            char_reg <= sig_char(word_idx, fetched);
            state <= ST_EMIT;
          end
        end
        ST_EMIT: begin
          if (!full) begin
            word_idx <= word_idx + 1'b1;
            state <= last_word ? ST_DRAIN : ST_REQUEST;
          end
        end
        ST_DRAIN: begin
          if (drained) state <= ST_IDLE;  // wait for uart to finish
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/uart_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_serializer (
  input logic clk,
  input logic read_address_ready,
  input logic start,
  input logic [7:0] data,
  output logic idle,
  output logic tx
);
  import fetch_pkg::*;

  logic active;
  logic [FRAME_BITS-1:0] shift_reg;  // stop, data, start; lsb goes out first
  logic [CYCLE_CNT_W-1:0] cycle_cnt;  // cycles within one bit
  logic [3:0] bit_cnt;  // bit within frame

  assign idle = !active;
  assign tx = shift_reg[0];  // all ones when idle

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      active <= 1'b0;
      shift_reg <= '1;  // line idles high
      cycle_cnt <= '0;
      bit_cnt <= '0;
    end else if (!active) begin
      if (start) begin
        shift_reg <= {1'b1, data, 1'b0};  // latch frame
        active <= 1'b1;
        cycle_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (cycle_cnt == CYCLE_CNT_W'(CLKS_PER_BIT - 1)) begin
      cycle_cnt <= '0;
      shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};  // next bit, fill with idle
      if (bit_cnt == 4'(FRAME_BITS - 1)) begin
        active <= 1'b0;  // stop bit done
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/uart_tx_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_buffer (
  input logic clk,
  input logic read_address_ready,
  input logic push,
  input logic [7:0] push_char,
  output logic full,
  output logic drained,
  output logic tx
);
  import fetch_pkg::*;

  logic [7:0] fifo_mem [0:FIFO_DEPTH-1];  // ring storage
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0] count;  // 0..FIFO_DEPTH
  logic do_push;
  logic do_pop;
  logic start;  // one-cycle kick to serializer
  logic [7:0] tx_char;
  logic idle;

  assign full = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop = idle && !start && (count != '0);  // serializer free, data waiting
  assign drained = (count == '0) && idle && !start;

  always_ff @(posedge clk) begin
    if (do_push) fifo_mem[wr_ptr] <= push_char;
    if (do_pop) tx_char <= fifo_mem[rd_ptr];
  end

  always_ff @(posedge clk or posedge read_address_ready) begin
    if (read_address_ready) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      start <= 1'b0;
    end else begin
      start <= do_pop;
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  uart_serializer uart_serializer_inst (
    .clk(clk),
    .read_address_ready(read_address_ready),
    .start(start),
    .data(tx_char),
    .idle(idle),
    .tx(tx)
  );

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input logic clk,
  input logic read_address_ready,  // async reset, active high
  input logic load_valid,
  input fetch_pkg::addr_t load_address,
  input fetch_pkg::word_t load_data,
  input logic run,
  output logic busy,
  output logic tx
);

  logic push;
  logic [7:0] push_char;
  logic full;
  logic drained;

  mem_read_if rd_bus ();  // fetcher <-> walker read channel

  page_walker page_walker_inst (
    .clk(clk),
    .read_address_ready(read_address_ready),
    .rd(rd_bus.responder),
    .load_valid(load_valid),  // host loads physical words
    .load_address(load_address),
    .load_data(load_data)
  );

  signature_fetcher signature_fetcher_inst (
    .clk(clk),
    .read_address_ready(read_address_ready),
    .run(run),
    .rd(rd_bus.requester),
    .push(push),
    .push_char(push_char),
    .full(full),
    .drained(drained),
    .busy(busy)
  );

  uart_tx_buffer uart_tx_buffer_inst (
    .clk(clk),
    .read_address_ready(read_address_ready),
    .push(push),
    .push_char(push_char),
    .full(full),
    .drained(drained),
    .tx(tx)
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;  // known level at time 0
  end

  always #(PERIOD_NS / 2) clk = ~clk;  // 50 percent duty

endmodule

`default_nettype wire

// File: tb/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
  import fetch_pkg::*;

  localparam int ROWS = 6;
  localparam int WORDS = 5;
  localparam int EXPECT_LEN = 6;  // banner + one char per word
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT = ROWS * 1300 + 200;
  localparam int WORD_BASE = 56;  // logical page 5 sits in segment 7
  localparam int DECOY_BASE = 40;  // identity address of logical 40
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  logic clk;
  logic read_address_ready;
  logic load_valid;
  addr_t load_address;
  word_t load_data;
  logic run;
  logic busy;
  logic tx;

  string row_name [0:ROWS-1];
  logic [15:0] row_words [0:ROWS-1][0:WORDS-1];  // at physical 56..60
  logic [15:0] row_decoys [0:ROWS-1][0:WORDS-1];  // at physical 40..44
  string row_expect [0:ROWS-1];

  logic [7:0] rx_chars [$];  // decoded from the tx line
  integer seed = 32'haa31feef;
  int cycle_count = 0;
  int line_errors = 0;  // framing problems seen by the decoder
  int setup_errors = 0;
  int pass_count = 0;
  int fail_count = 0;

  tb_clock_gen #(.PERIOD_NS(20)) clock_inst (.clk(clk));

  fetch_top fetch_top_inst (
    .clk(clk),
    .read_address_ready(read_address_ready),
    .load_valid(load_valid),
    .load_address(load_address),
    .load_data(load_data),
    .run(run),
    .busy(busy),
    .tx(tx)
  );

  function automatic logic [15:0] random_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // nudge a random word off its signature entry
  function automatic logic [15:0] miss_word(input int idx, input logic [15:0] w);
    logic [15:0] m;
    m = w;
    if ((idx == 0 || idx == 2) && m[15:8] == 8'h0C) m[15:8] = 8'hF3;  // opcode view
    if (idx == 1 && m == 16'h0001) m = 16'h8001;
    if (idx == 3 && m == 16'h0002) m = 16'h8002;
    if (idx == 4 && m == 16'h0402) m = 16'h8402;
    return m;
  endfunction

  task automatic fill_table();
    row_name[0] = "full_signature";
    row_words[0] = '{16'h0C01, 16'h0001, 16'h0C01, 16'h0002, 16'h0402};
    for (int i = 0; i < WORDS; i++) row_decoys[0][i] = random_word();
    row_expect[0] = "MARCIN";
    row_name[1] = "opcode_view";
    row_words[1] = '{16'h0CFF, 16'h0001, 16'h0C00, 16'h0002, 16'h0402};  // operand ignored
    for (int i = 0; i < WORDS; i++) row_decoys[1][i] = random_word();
    row_expect[1] = "MARCIN";
    row_name[2] = "raw_view";
    row_words[2] = '{16'h0C01, 16'h0101, 16'h0C01, 16'h0002, 16'h0403};  // full word counts
    for (int i = 0; i < WORDS; i++) row_decoys[2][i] = random_word();
    row_expect[2] = "MAXCIX";
    row_name[3] = "all_wrong";
    for (int i = 0; i < WORDS; i++) begin
      row_words[3][i] = miss_word(i, random_word());
      row_decoys[3][i] = random_word();
    end
    row_expect[3] = "MXXXXX";
    row_name[4] = "decoys_only";
    row_words[4] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
    row_decoys[4] = '{16'h0C01, 16'h0001, 16'h0C01, 16'h0002, 16'h0402};  // bait at identity
    row_expect[4] = "MXXXXX";
    row_name[5] = "repeat_run";
    row_words[5] = row_words[0];  // same as first row, no reset between
    row_decoys[5] = row_decoys[0];
    row_expect[5] = row_expect[0];
  endtask

  task automatic load_word(input int address, input logic [15:0] data);
    @(posedge clk);
    load_valid <= 1'b1;
    load_address <= addr_t'(address);
    load_data <= data;
  endtask

  task automatic run_row(input int r);
    string actual;
    int errors_before;
    int wait_cycles;
    int row_errors;
    errors_before = line_errors;
    row_errors = 0;
    wait_cycles = 0;
    actual = "";
    for (int i = 0; i < WORDS; i++) load_word(DECOY_BASE + i, row_decoys[r][i]);
    for (int i = 0; i < WORDS; i++) load_word(WORD_BASE + i, row_words[r][i]);
    rx_chars.delete();
    @(posedge clk);
    load_valid <= 1'b0;
    run <= 1'b1;  // last word commits on this edge
    @(posedge clk);
    run <= 1'b0;
    while (busy !== 1'b1 && wait_cycles < 4) begin
      @(posedge clk);
      wait_cycles++;
    end
    assert (busy === 1'b1) else begin
      $display("test %s: busy did not rise after run", row_name[r]);
      row_errors++;
    end
    while (busy === 1'b1) @(posedge clk);  // watchdog covers a stuck busy
    foreach (rx_chars[i]) actual = $sformatf("%s%c", actual, rx_chars[i]);
    assert (rx_chars.size() == EXPECT_LEN) else begin
      $display("test %s: only %0d of %0d characters arrived before busy fell",
               row_name[r], rx_chars.size(), EXPECT_LEN);
      row_errors++;
    end
    assert (actual == row_expect[r]) else begin
      $display("FAILED %s expected %s actual %s", row_name[r], row_expect[r], actual);
      row_errors++;
    end
    if (row_errors == 0 && line_errors == errors_before) begin
      pass_count++;
      $display("test %s: pass (%s)", row_name[r], actual);
    end else begin
      fail_count++;
      $display("test %s: fail", row_name[r]);
    end
  endtask

  // 8N1 receiver, samples each bit near its middle
  initial begin : line_decoder
    logic [7:0] ch;
    wait (read_address_ready == 1'b0);
    forever begin
      @(posedge clk);
      if (tx == 1'b0) begin
        repeat (HALF_BIT - 1) @(posedge clk);  // middle of start bit
        assert (tx == 1'b0) else begin
          $display("start bit did not hold low at mid-bit");
          line_errors++;
        end
        for (int b = 0; b < 8; b++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          ch[b] = tx;  // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        assert (tx == 1'b1) else begin
          $display("stop bit missing after character %02h", ch);
          line_errors++;
        end
        rx_chars.push_back(ch);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, run stopped", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin : main_sequence
    read_address_ready = 1'b1;  // reset held from time 0
    load_valid = 1'b0;
    load_address = '0;
    load_data = '0;
    run = 1'b0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    read_address_ready <= 1'b0;
    @(posedge clk);
    assert (tx === 1'b1 && busy === 1'b0) else begin
      $display("outputs not idle after reset, tx=%b busy=%b", tx, busy);
      setup_errors++;
    end
    for (int r = 0; r < ROWS; r++) run_row(r);
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && setup_errors == 0 && line_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
src/fetch_pkg.sv
src/mem_read_if.sv
src/program_ram.sv
src/page_walker.sv
src/signature_fetcher.sv
src/uart_serializer.sv
src/uart_tx_buffer.sv
src/fetch_top.sv
tb/tb_clock_gen.sv
tb/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
exit 0
